//--- Makefile
TOP = tb_npc_predictor
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f npc_predictor.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- npc_predictor.f
rtl/npc_pred_pkg.sv
rtl/pred_update_if.sv
rtl/btb.sv
rtl/ras.sv
rtl/cpht.sv
rtl/npc_predictor.sv
tests/npc_predictor_props.sv
tests/tb_npc_predictor.sv

//--- rtl/btb.sv
module btb import npc_pred_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  addr_t    pc,
    input  pc_hash_t pc_hash,
    input  bh_hash_t bh_hash,
    pred_update_if.sink upd,
    output addr_t    target
);

    // valid bits are the only state cleared by reset
    logic [TABLE_DEPTH-1:0] valid_q;
    addr_t tag_q [TABLE_DEPTH];
    addr_t target_q [TABLE_DEPTH];

    pc_hash_t rd_idx;
    pc_hash_t wr_idx;
    logic     wr_en;
    logic     hit;

    // index mixes the pc hash with the history hash
    function automatic pc_hash_t btb_index(input pc_hash_t ph, input bh_hash_t bh);
        pc_hash_t bh_ext;
        bh_ext = pc_hash_t'(bh);
        return ph ^ bh_ext;
    endfunction

    assign rd_idx = btb_index(pc_hash, bh_hash);
    assign wr_idx = btb_index(upd.pc_hash, upd.bh_hash);

    // only taken branches carry a useful target
    assign wr_en = upd.valid && upd.taken && (upd.kind != NOT_JUMP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= upd.pc;
            target_q[wr_idx] <= upd.target;
        end
    end

    // full address as tag, so aliasing pcs fall back to sequential
    assign hit = valid_q[rd_idx] && (tag_q[rd_idx] == pc);

    always_comb begin
        if (hit) begin
            target = target_q[rd_idx];
        end else begin
            target = seq_npc(pc);
        end
    end

endmodule

//--- rtl/cpht.sv
module cpht import npc_pred_pkg::*; (
    input  logic     clk,
    input  pc_hash_t pc_hash,
    pred_update_if.sink upd,
    output logic     choice,
    output ctr_t     ctr
);

    // one 2-bit counter per pc hash
    ctr_t table_q [TABLE_DEPTH];

    ctr_t ctr_nxt;
    logic wr_en;

    // only returns choose between btb and stack
    assign wr_en = upd.valid && (upd.kind == RET);

    // step the carried value toward the real outcome
    always_comb begin
        ctr_nxt = upd.choice_ctr;
        if (upd.choice_real) begin
            if (upd.choice_ctr != CTR_MAX) begin
                ctr_nxt = upd.choice_ctr + ctr_t'(1);
            end
        end else begin
            if (upd.choice_ctr != CTR_MIN) begin
                ctr_nxt = upd.choice_ctr - ctr_t'(1);
            end
        end
    end

    // the carried counter saves a read port on the commit side
    always_ff @(posedge clk) begin
        if (wr_en) begin
            table_q[upd.pc_hash] <= ctr_nxt;
        end
    end

    assign ctr    = table_q[pc_hash];
    assign choice = ctr[1];

endmodule

//--- rtl/npc_pred_pkg.sv
package npc_pred_pkg;

    // fetch address, counted in instruction units
    localparam int ADDR_W = 30;

    // hash widths supplied by the front end
    localparam int HIST_W = 8;
    localparam int IDX_W = 12;

    // entries in the btb and the choice table
    localparam int TABLE_DEPTH = 1 << IDX_W;

    // return address stack geometry
    localparam int RAS_DEPTH = 16;
    localparam int RAS_PTR_W = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [HIST_W-1:0] bh_hash_t;
    typedef logic [IDX_W-1:0] pc_hash_t;
    typedef logic [RAS_PTR_W-1:0] ras_ptr_t;

    // upper bit set selects the btb, clear selects the stack
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_MIN = 2'b00;
    localparam ctr_t CTR_MAX = 2'b11;

    // codes 2 and 3 are unused and behave like NOT_JUMP
    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,
        RET           = 3'd4,
        INDIRECT_JUMP = 3'd5,
        CALL          = 3'd6,
        JUMP          = 3'd7
    } br_kind_e;

    // sequential fetch: odd addresses step by one, even ones by two
    function automatic addr_t seq_npc(input addr_t pc);
        addr_t step;
        if (pc[0]) begin
            step = addr_t'(1);
        end else begin
            step = addr_t'(2);
        end
        return pc + step;
    endfunction

endpackage

//--- rtl/npc_predictor.sv
module npc_predictor import npc_pred_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,

    // commit from execute
    input  logic     update_en,
    input  logic     taken_ex,
    input  br_kind_e kind_ex,
    input  addr_t    pc_ex,
    input  addr_t    npc_ex,
    input  pc_hash_t pc_ex_hashed,
    input  bh_hash_t pc_ex_bh_hashed,
    input  addr_t    ret_pc_ex,
    input  logic     choice_real,
    input  ctr_t     choice_pdch_ex,
    input  logic     mis_pdc,

    // current fetch
    input  addr_t    pc_reg,
    input  pc_hash_t pc_hashed_reg,
    input  bh_hash_t pc_bh_hashed,
    input  br_kind_e kind_pdc,
    input  logic     taken_pdc,

    output addr_t    npc_pdc,
    // 1 selects the btb, 0 the stack
    output logic     choice_btb_ras,
    output ctr_t     choice_pdch
);

    pred_update_if upd ();

    addr_t npc_seq;
    addr_t npc_btb;
    addr_t npc_ras;

    // every table sees the same commit, each filters by kind
    assign upd.valid       = update_en;
    assign upd.taken       = taken_ex;
    assign upd.kind        = kind_ex;
    assign upd.pc          = pc_ex;
    assign upd.target      = npc_ex;
    assign upd.pc_hash     = pc_ex_hashed;
    assign upd.bh_hash     = pc_ex_bh_hashed;
    assign upd.ret_pc      = ret_pc_ex;
    assign upd.choice_real = choice_real;
    assign upd.choice_ctr  = choice_pdch_ex;
    assign upd.addr_mis    = mis_pdc;

    btb u_btb (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc      (pc_reg),
        .pc_hash (pc_hashed_reg),
        .bh_hash (pc_bh_hashed),
        .upd     (upd.sink),
        .target  (npc_btb)
    );

    ras u_ras (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .pred_kind (kind_pdc),
        .upd       (upd.sink),
        .top       (npc_ras)
    );

    cpht u_cpht (
        .clk     (clk),
        .pc_hash (pc_hashed_reg),
        .upd     (upd.sink),
        .choice  (choice_btb_ras),
        .ctr     (choice_pdch)
    );

    assign npc_seq = seq_npc(pc_reg);

    // next fetch address by predicted kind
    always_comb begin
        npc_pdc = npc_seq;
        if (taken_pdc) begin
            case (kind_pdc)
                DIRECT_JUMP, INDIRECT_JUMP, CALL, JUMP: begin
                    npc_pdc = npc_btb;
                end
                RET: begin
                    npc_pdc = choice_btb_ras ? npc_btb : npc_ras;
                end
                // NOT_JUMP and the unused codes
                default: begin
                    npc_pdc = npc_seq;
                end
            endcase
        end
    end

endmodule

//--- rtl/pred_update_if.sv
interface pred_update_if import npc_pred_pkg::*; ();

    // commit strobe, one branch per cycle
    logic     valid;
    logic     taken;
    br_kind_e kind;
    addr_t    pc;
    addr_t    target;
    pc_hash_t pc_hash;
    bh_hash_t bh_hash;
    // return address of a committed call
    addr_t    ret_pc;
    // 1 when the btb target was the right one for a return
    logic     choice_real;
    // counter value read at prediction time
    ctr_t     choice_ctr;
    logic     addr_mis;

    // execute side drives the commit
    modport src (
        output valid, taken, kind, pc, target,
        output pc_hash, bh_hash, ret_pc,
        output choice_real, choice_ctr, addr_mis
    );

    // tables only observe the commit
    modport sink (
        input valid, taken, kind, pc, target,
        input pc_hash, bh_hash, ret_pc,
        input choice_real, choice_ctr, addr_mis
    );

endinterface

//--- rtl/ras.sv
module ras import npc_pred_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  br_kind_e pred_kind,
    pred_update_if.sink upd,
    output addr_t    top
);

    addr_t stack_q [RAS_DEPTH];

    // committed pointer follows execute, speculative pointer follows fetch
    ras_ptr_t commit_ptr;
    ras_ptr_t spec_ptr;
    ras_ptr_t commit_ptr_nxt;
    ras_ptr_t spec_ptr_nxt;

    logic push;
    logic pop_commit;
    logic pop_pred;
    logic recover;

    assign push       = upd.valid && (upd.kind == CALL);
    assign pop_commit = upd.valid && (upd.kind == RET);
    assign pop_pred   = !stall && (pred_kind == RET);

    // miss blamed on the stack when the carried counter chose it
    assign recover = upd.valid && upd.addr_mis && !upd.choice_ctr[1];

    always_comb begin
        commit_ptr_nxt = commit_ptr;
        if (push) begin
            commit_ptr_nxt = commit_ptr + ras_ptr_t'(1);
        end else if (pop_commit) begin
            commit_ptr_nxt = commit_ptr - ras_ptr_t'(1);
        end
    end

    // recovery wins over the normal push/pop sum
    always_comb begin
        if (recover) begin
            spec_ptr_nxt = commit_ptr_nxt;
        end else begin
            spec_ptr_nxt = spec_ptr + ras_ptr_t'(push) - ras_ptr_t'(pop_pred);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_ptr <= '0;
            spec_ptr   <= '0;
        end else begin
            commit_ptr <= commit_ptr_nxt;
            spec_ptr   <= spec_ptr_nxt;
        end
    end

    // circular, so a deep call chain overwrites the oldest entry
    always_ff @(posedge clk) begin
        if (push) begin
            stack_q[commit_ptr_nxt] <= upd.ret_pc;
        end
    end

    assign top = stack_q[spec_ptr];

endmodule

//--- tests/npc_predictor_props.sv
module npc_predictor_props import npc_pred_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     stall,
    input logic     update_en,
    input logic     taken_pdc,
    input addr_t    pc_reg,
    input addr_t    npc_pdc,
    input ras_ptr_t spec_ptr,
    input ras_ptr_t commit_ptr
);

    timeunit 1ns;
    timeprecision 1ps;

    addr_t seq_addr;

    // odd fetch addresses step by one, even ones by two
    assign seq_addr = pc_reg[0] ? (pc_reg + addr_t'(1)) : (pc_reg + addr_t'(2));

    seq_when_not_taken: assert property (
        @(posedge clk) disable iff (!rst_n)
        !taken_pdc |-> (npc_pdc == seq_addr)
    ) else $error("npc_pdc is not the sequential address while taken_pdc is low");

    // a stalled fetch with no commit keeps the speculative pointer
    spec_held_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall && !update_en) |=> $stable(spec_ptr)
    ) else $error("speculative stack pointer moved while stall was high");

    npc_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(npc_pdc)
    ) else $error("npc_pdc carries X or Z");

    // both stack pointers held at zero during reset
    ptrs_reset: assert property (
        @(posedge clk)
        !rst_n |-> (spec_ptr == '0 && commit_ptr == '0)
    ) else $error("stack pointers are not zero during reset");

endmodule

//--- tests/tb_npc_predictor.sv
module tb_npc_predictor import npc_pred_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 5;
    localparam int RESET_TIMEOUT = 50;
    localparam int SEED = 47947;
    localparam pc_hash_t RET_HASH = 12'h5a5;
    localparam pc_hash_t CTR_HASH = 12'h0f3;
    localparam bh_hash_t RET_BH = 8'h3c;

    logic     clk;
    logic     rst_n;
    logic     stall;
    logic     update_en;
    logic     taken_ex;
    br_kind_e kind_ex;
    addr_t    pc_ex;
    addr_t    npc_ex;
    pc_hash_t pc_ex_hashed;
    bh_hash_t pc_ex_bh_hashed;
    addr_t    ret_pc_ex;
    logic     choice_real;
    ctr_t     choice_pdch_ex;
    logic     mis_pdc;
    addr_t    pc_reg;
    pc_hash_t pc_hashed_reg;
    bh_hash_t pc_bh_hashed;
    br_kind_e kind_pdc;
    logic     taken_pdc;
    addr_t    npc_pdc;
    logic     choice_btb_ras;
    ctr_t     choice_pdch;

    // reference model of written entries and stack state
    addr_t    m_tag [int];
    addr_t    m_tgt [int];
    ctr_t     m_ctr [int];
    addr_t    m_stack [RAS_DEPTH];
    ras_ptr_t m_cptr;
    ras_ptr_t m_sptr;

    npc_predictor u_npc_predictor (.*);

    bind npc_predictor npc_predictor_props u_props (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .update_en      (update_en),
        .taken_pdc      (taken_pdc),
        .pc_reg         (pc_reg),
        .npc_pdc        (npc_pdc),
        .spec_ptr       (u_ras.spec_ptr),
        .commit_ptr     (u_ras.commit_ptr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    end

    function automatic addr_t seq_step(input addr_t pc);
        if (pc[0]) begin
            return pc + addr_t'(1);
        end
        return pc + addr_t'(2);
    endfunction

    function automatic int table_index(input pc_hash_t ph, input bh_hash_t bh);
        return int'(ph ^ {{(IDX_W-HIST_W){1'b0}}, bh});
    endfunction

    function automatic addr_t btb_expect(input addr_t pc, input pc_hash_t ph, input bh_hash_t bh);
        int idx;
        idx = table_index(ph, bh);
        if (m_tag.exists(idx) && m_tag[idx] == pc) begin
            return m_tgt[idx];
        end
        return seq_step(pc);
    endfunction

    // one saturating step toward the real outcome
    function automatic ctr_t ctr_step(input ctr_t c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    task automatic check_value(input string name, input addr_t exp, input addr_t act);
        assert (act === exp) else begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic commit_branch(input br_kind_e kind, input logic taken, input addr_t pc,
                                 input addr_t tgt, input pc_hash_t ph, input bh_hash_t bh,
                                 input addr_t ret, input logic choice_ok, input ctr_t cctr,
                                 input logic mis);
        int idx;
        ras_ptr_t cptr_new;
        update_en = 1'b1;
        taken_ex = taken;
        kind_ex = kind;
        pc_ex = pc;
        npc_ex = tgt;
        pc_ex_hashed = ph;
        pc_ex_bh_hashed = bh;
        ret_pc_ex = ret;
        choice_real = choice_ok;
        choice_pdch_ex = cctr;
        mis_pdc = mis;
        idx = table_index(ph, bh);
        if (taken && kind != NOT_JUMP) begin
            m_tag[idx] = pc;
            m_tgt[idx] = tgt;
        end
        if (kind == RET) begin
            m_ctr[int'(ph)] = ctr_step(cctr, choice_ok);
        end
        cptr_new = m_cptr;
        if (kind == CALL) begin
            cptr_new = m_cptr + ras_ptr_t'(1);
            m_stack[cptr_new] = ret;
        end else if (kind == RET) begin
            cptr_new = m_cptr - ras_ptr_t'(1);
        end
        // a stack-blamed miss resyncs the speculative pointer
        if (mis && !cctr[1]) begin
            m_sptr = cptr_new;
        end else if (kind == CALL) begin
            m_sptr = m_sptr + ras_ptr_t'(1);
        end
        m_cptr = cptr_new;
        @(negedge clk);
        update_en = 1'b0;
        mis_pdc = 1'b0;
    endtask

    task automatic predict_check(input br_kind_e kind, input logic taken, input addr_t pc,
                                 input pc_hash_t ph, input bh_hash_t bh);
        addr_t exp;
        exp = seq_step(pc);
        if (taken) begin
            case (kind)
                DIRECT_JUMP, INDIRECT_JUMP, CALL, JUMP: exp = btb_expect(pc, ph, bh);
                RET: begin
                    if (m_ctr[int'(ph)][1]) begin
                        exp = btb_expect(pc, ph, bh);
                    end else begin
                        exp = m_stack[m_sptr];
                    end
                end
                default: exp = seq_step(pc);
            endcase
        end
        pc_reg = pc;
        pc_hashed_reg = ph;
        pc_bh_hashed = bh;
        kind_pdc = kind;
        taken_pdc = taken;
        #5;
        check_value("npc_pdc", exp, npc_pdc);
        if (m_ctr.exists(int'(ph))) begin
            check_value("choice_pdch", addr_t'(m_ctr[int'(ph)]), addr_t'(choice_pdch));
            check_value("choice_btb_ras", addr_t'(m_ctr[int'(ph)][1]),
                        addr_t'(choice_btb_ras));
        end
        if (kind == RET && !stall) begin
            m_sptr = m_sptr - ras_ptr_t'(1);
        end
        @(negedge clk);
        kind_pdc = NOT_JUMP;
        taken_pdc = 1'b0;
    endtask

    initial begin
        int wait_cycles;
        addr_t pc;
        addr_t tgt;
        pc_hash_t ph;
        bh_hash_t bh;
        addr_t rets [3];
        br_kind_e kinds [4];
        void'($urandom(SEED));
        stall = 1'b0;
        update_en = 1'b0;
        taken_ex = 1'b0;
        kind_ex = NOT_JUMP;
        pc_ex = '0;
        npc_ex = '0;
        pc_ex_hashed = '0;
        pc_ex_bh_hashed = '0;
        ret_pc_ex = '0;
        choice_real = 1'b0;
        choice_pdch_ex = '0;
        mis_pdc = 1'b0;
        pc_reg = '0;
        pc_hashed_reg = '0;
        pc_bh_hashed = '0;
        kind_pdc = NOT_JUMP;
        taken_pdc = 1'b0;
        m_cptr = '0;
        m_sptr = '0;

        wait_cycles = 0;
        while (!rst_n) begin
            if (wait_cycles == RESET_TIMEOUT) begin
                $display("reset was not released within %0d cycles", RESET_TIMEOUT);
                $display("TESTS FAILED");
                $fatal(1);
            end
            @(negedge clk);
            wait_cycles++;
        end

        // sequential fetch, including the undefined kinds
        for (int i = 0; i < 24; i++) begin
            pc = addr_t'($urandom);
            ph = pc_hash_t'($urandom);
            bh = bh_hash_t'($urandom);
            case (i % 3)
                0: predict_check(JUMP, 1'b0, pc, ph, bh);
                1: predict_check(NOT_JUMP, 1'b1, pc, ph, bh);
                default: predict_check(br_kind_e'(3'(2 + i % 2)), 1'b1, pc, ph, bh);
            endcase
        end

        // btb training, then an aliasing pc on the same index
        kinds = '{DIRECT_JUMP, INDIRECT_JUMP, CALL, JUMP};
        foreach (kinds[k]) begin
            pc = addr_t'($urandom);
            tgt = addr_t'($urandom);
            ph = pc_hash_t'($urandom);
            bh = bh_hash_t'($urandom);
            commit_branch(kinds[k], 1'b1, pc, tgt, ph, bh, addr_t'($urandom), 1'b0, 2'd0, 1'b0);
            predict_check(kinds[k], 1'b1, pc, ph, bh);
            predict_check(kinds[k], 1'b1, pc ^ addr_t'(30'h100), ph, bh);
        end

        // counter toward the stack, with recovery to line up the pointers
        pc = addr_t'($urandom);
        commit_branch(RET, 1'b0, pc, '0, RET_HASH, RET_BH, '0, 1'b0, 2'd1, 1'b1);
        for (int i = 0; i < 3; i++) begin
            rets[i] = addr_t'($urandom);
            commit_branch(CALL, 1'b1, addr_t'($urandom), addr_t'($urandom),
                          pc_hash_t'($urandom), bh_hash_t'($urandom), rets[i],
                          1'b0, 2'd0, 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            predict_check(RET, 1'b1, pc, RET_HASH, RET_BH);
        end

        // every carried counter with both outcomes
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 2; r++) begin
                commit_branch(RET, 1'b0, pc, '0, CTR_HASH, RET_BH, '0, (r == 1), ctr_t'(c), 1'b0);
                predict_check(NOT_JUMP, 1'b0, pc, CTR_HASH, RET_BH);
            end
        end
        pc = addr_t'($urandom);
        tgt = addr_t'($urandom);
        commit_branch(RET, 1'b1, pc, tgt, CTR_HASH, RET_BH, '0, 1'b1, 2'd2, 1'b0);
        predict_check(RET, 1'b1, pc, CTR_HASH, RET_BH);

        // stall holds the top and a stack-blamed miss restores it
        commit_branch(NOT_JUMP, 1'b0, '0, '0, '0, '0, '0, 1'b0, 2'd0, 1'b1);
        for (int i = 0; i < 2; i++) begin
            rets[i] = addr_t'($urandom);
            commit_branch(CALL, 1'b0, addr_t'($urandom), '0, '0, '0, rets[i], 1'b0, 2'd0, 1'b0);
        end
        pc = addr_t'($urandom);
        stall = 1'b1;
        predict_check(RET, 1'b1, pc, RET_HASH, RET_BH);
        predict_check(RET, 1'b1, pc, RET_HASH, RET_BH);
        stall = 1'b0;
        predict_check(RET, 1'b1, pc, RET_HASH, RET_BH);
        predict_check(RET, 1'b1, pc, RET_HASH, RET_BH);
        commit_branch(NOT_JUMP, 1'b0, '0, '0, '0, '0, '0, 1'b0, 2'd1, 1'b1);
        predict_check(RET, 1'b1, pc, RET_HASH, RET_BH);

        $display("TESTS PASSED");
        $finish;
    end

endmodule
